/* hdl/bru_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// rv32i width constants
// word, address and instruction vector types
// ~~~~~~~~~~~~~~~~~~~~

package bru_cfg_pkg;

    // fixed by the isa
    localparam int XLEN   = 32;  // data word width
    localparam int ADDR_W = 32;  // fetch address width
    localparam int ILEN   = 32;  // no compressed support

    // register file value, also compare and adder operand
    typedef logic [XLEN-1:0] word_t;

    // instruction address, pc and redirect targets
    typedef logic [ADDR_W-1:0] addr_t;

    // raw instruction word as issued
    typedef logic [ILEN-1:0] inst_t;

endpackage : bru_cfg_pkg

/* hdl/bru_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// branch op flags, decoder request, resolution
// fetch redirect payload, redirect fsm states
// ~~~~~~~~~~~~~~~~~~~~

package bru_types_pkg;

    import bru_cfg_pkg::*;

    // one-hot-ish op flags out of the decoder
    typedef struct packed {
        logic jump;   // jal or jalr
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
        logic jalr;   // only jalr, jump also set
        logic fence;  // flush and refetch pc+4
    } bjp_op_t;

    // decoder -> resolver
    typedef struct packed {
        logic    req;       // branch or jump opcode
        bjp_op_t op;
        word_t   op1;       // compare operands, rs1
        word_t   op2;       // rs2
        word_t   jump_op1;  // target adder inputs
        word_t   jump_op2;
        logic    is_pred;   // fetch guessed taken
        word_t   link;      // pc+4 for rd
    } bjp_req_t;

    // resolver -> redirect register
    typedef struct packed {
        logic  jump_flag;   // fetch must be redirected
        addr_t jump_addr;
        logic  misaligned;  // target not word aligned
        logic  is_link;     // jal/jalr writes rd
        word_t link;
    } bru_res_t;

    typedef struct packed {
        addr_t addr;
    } redirect_t;

    typedef enum logic {
        IDLE,  // nothing pending, issue open
        HOLD   // redirect waiting on fetch
    } redir_state_e;

endpackage : bru_types_pkg

/* hdl/branch_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// rv32i control flow decoder
// op flags, operands, btfn static guess
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module branch_decoder import bru_cfg_pkg::*, bru_types_pkg::*; (
    input  inst_t    inst_i,
    input  addr_t    pc_i,
    input  word_t    rs1_i,
    input  word_t    rs2_i,
    output bjp_req_t req_o
);

    // major opcodes we care about
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;  // misc-mem, fence and fence.i

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_j;
    word_t      imm_b;
    word_t      imm_i;
    word_t      pc_plus4;
    logic       is_jal;
    logic       is_jalr;
    logic       is_branch;
    logic       is_fence;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // immediates, all sign extended from bit 31
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};

    assign pc_plus4 = pc_i + word_t'(4);

    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR) && (funct3 == 3'b000);
    assign is_branch = (opcode == OPC_BRANCH) && (funct3[2:1] != 2'b01);  // 010/011 reserved
    assign is_fence  = (opcode == OPC_FENCE);

    always_comb begin : decode
        req_o          = '0;
        req_o.req      = is_jal | is_jalr | is_branch;
        req_o.op1      = rs1_i;
        req_o.op2      = rs2_i;
        req_o.link     = pc_plus4;
        // btfn: backward branch assumed taken by fetch
        req_o.is_pred  = is_branch & imm_b[31];

        req_o.op.jump  = is_jal | is_jalr;
        req_o.op.jalr  = is_jalr;
        req_o.op.fence = is_fence;

        // branch flavours straight from funct3
        if (is_branch) begin
            case (funct3)
                3'b000:  req_o.op.beq  = 1'b1;
                3'b001:  req_o.op.bne  = 1'b1;
                3'b100:  req_o.op.blt  = 1'b1;
                3'b101:  req_o.op.bge  = 1'b1;
                3'b110:  req_o.op.bltu = 1'b1;
                3'b111:  req_o.op.bgeu = 1'b1;
                default: req_o.op.beq  = 1'b0;  // filtered above
            endcase
        end

        // target adder operands
        if (is_jalr) begin
            req_o.jump_op1 = rs1_i;      // rs1 + imm
            req_o.jump_op2 = imm_i;
        end else if (is_jal) begin
            req_o.jump_op1 = pc_i;
            req_o.jump_op2 = imm_j;
        end else if (is_branch) begin
            req_o.jump_op1 = pc_i;
            req_o.jump_op2 = imm_b;
        end else begin
            // fence and everything else, refetch next
            req_o.jump_op1 = pc_i;
            req_o.jump_op2 = word_t'(4);
        end
    end

endmodule : branch_decoder

/* hdl/exu_bru.sv */
// ~~~~~~~~~~~~~~~~~~~~
// branch resolution, compare and target adder
// rollback, interrupt override, misalign check
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exu_bru import bru_cfg_pkg::*, bru_types_pkg::*; (
    input  bjp_req_t req_i,
    input  logic     int_assert_i,
    input  addr_t    int_addr_i,
    output bru_res_t res_o
);

    logic  op1_eq_op2;
    logic  op1_ge_op2_signed;
    logic  op1_ge_op2_unsigned;
    logic  branch_cond;
    logic  pred_rollback;
    word_t adder_op2;
    word_t adder_sum;
    addr_t target_addr;
    logic  jump_flag;
    logic  misaligned;

    // comparator, shared by all six branches
    assign op1_eq_op2          = (req_i.op1 == req_i.op2);
    assign op1_ge_op2_signed   = $signed(req_i.op1) >= $signed(req_i.op2);
    assign op1_ge_op2_unsigned = req_i.op1 >= req_i.op2;

    // taken, jumps count as always taken
    assign branch_cond = req_i.req & (
        (req_i.op.beq  &  op1_eq_op2)          |
        (req_i.op.bne  & ~op1_eq_op2)          |
        (req_i.op.blt  & ~op1_ge_op2_signed)   |
        (req_i.op.bge  &  op1_ge_op2_signed)   |
        (req_i.op.bltu & ~op1_ge_op2_unsigned) |
        (req_i.op.bgeu &  op1_ge_op2_unsigned) |
        req_i.op.jump
    );

    // fetch went backward but branch falls through
    assign pred_rollback = req_i.req & req_i.is_pred & ~branch_cond;

    // one adder, rollback turns it into pc+4
    assign adder_op2 = pred_rollback ? word_t'(4) : req_i.jump_op2;
    assign adder_sum = req_i.jump_op1 + adder_op2;

    // interrupt wins, jalr drops bit 0
    always_comb begin : target_sel
        if (int_assert_i) begin
            target_addr = int_addr_i;
        end else if (req_i.op.jalr) begin
            target_addr = {adder_sum[XLEN-1:1], 1'b0};
        end else begin
            target_addr = adder_sum;
        end
    end

    // correctly guessed taken branch needs nothing
    assign jump_flag = int_assert_i
                     | (branch_cond & ~req_i.is_pred)
                     | req_i.op.fence
                     | pred_rollback;

    // jump_flag already covers jal and jalr
    assign misaligned = (target_addr[1:0] != 2'b00) & jump_flag;

    assign res_o.jump_flag  = jump_flag & ~misaligned;  // exception replaces redirect
    assign res_o.jump_addr  = target_addr;
    assign res_o.misaligned = misaligned;
    // no rd write if the jump traps or is overridden
    assign res_o.is_link    = req_i.op.jump & ~int_assert_i & ~misaligned;
    assign res_o.link       = req_i.link;

endmodule : exu_bru

/* hdl/redirect_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// redirect register and idle/hold fsm
// exception and link pulses, issue gating
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module redirect_unit import bru_cfg_pkg::*, bru_types_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      accept_i,
    input  bru_res_t  res_i,
    input  logic      redirect_ready_i,
    output logic      issue_ready_o,
    output logic      redirect_valid_o,
    output redirect_t redirect_o,
    output logic      misaligned_o,
    output addr_t     misaligned_addr_o,
    output logic      link_valid_o,
    output word_t     link_o
);

    redir_state_e state_q;
    redir_state_e state_d;
    logic         capture;          // resolution taken this edge
    logic         misaligned_q;
    logic         link_valid_q;
    addr_t        target_q;         // redirect or faulting address
    word_t        link_q;

    assign capture = accept_i & (state_q == IDLE);

    always_comb begin : next_state
        state_d = state_q;
        case (state_q)
            IDLE:    if (capture && res_i.jump_flag) state_d = HOLD;
            HOLD:    if (redirect_ready_i) state_d = IDLE;  // fetch took it
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            misaligned_q <= 1'b0;
            link_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            misaligned_q <= capture & res_i.misaligned;  // single cycle
            link_valid_q <= capture & res_i.is_link;
        end
    end

    // payload, frozen while holding
    always_ff @(posedge clk) begin
        if (capture) begin
            target_q <= res_i.jump_addr;
            link_q   <= res_i.link;
        end
    end

    assign issue_ready_o     = (state_q == IDLE);  // closed until redirect gone
    assign redirect_valid_o  = (state_q == HOLD);
    assign redirect_o.addr   = target_q;
    assign misaligned_o      = misaligned_q;
    assign misaligned_addr_o = target_q;
    assign link_valid_o      = link_valid_q;
    assign link_o            = link_q;

    // stalled redirect must not move or drop
    a_redirect_stable: assert property (@(posedge clk) disable iff (reset_i)
        redirect_valid_o && !redirect_ready_i |=> redirect_valid_o && $stable(redirect_o))
        else $error("redirect changed while fetch stalled");

    // a trap never comes with a redirect
    a_excl_misaligned: assert property (@(posedge clk) disable iff (reset_i)
        !(misaligned_o && redirect_valid_o))
        else $error("misaligned and redirect both high");

    a_reset_quiet: assert property (@(posedge clk)
        reset_i |=> !redirect_valid_o && !misaligned_o && !link_valid_o && issue_ready_o)
        else $error("outputs not quiet after reset");

endmodule : redirect_unit

/* hdl/branch_unit_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// branch unit top, decoder to resolver
// to redirect register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module branch_unit_top import bru_cfg_pkg::*, bru_types_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    // issue side
    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  inst_t     issue_inst_i,
    input  addr_t     issue_pc_i,
    input  word_t     rs1_i,
    input  word_t     rs2_i,
    // external interrupt
    input  logic      int_assert_i,
    input  addr_t     int_addr_i,
    // fetch redirect
    output logic      redirect_valid_o,
    input  logic      redirect_ready_i,
    output redirect_t redirect_o,
    // exception and rd write
    output logic      misaligned_o,
    output addr_t     misaligned_addr_o,
    output logic      link_valid_o,
    output word_t     link_o
);

    bjp_req_t dec_req;
    bru_res_t bru_res;
    logic     accept;

    // handshake, an idle interrupt is taken on its own
    assign accept = issue_ready_o & (issue_valid_i | int_assert_i);

    branch_decoder u_decoder (
        .inst_i (issue_inst_i),
        .pc_i   (issue_pc_i),
        .rs1_i  (rs1_i),
        .rs2_i  (rs2_i),
        .req_o  (dec_req)
    );

    exu_bru u_bru (
        .req_i        (dec_req),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .res_o        (bru_res)
    );

    redirect_unit u_redirect (
        .clk               (clk),
        .reset_i           (reset_i),
        .accept_i          (accept),
        .res_i             (bru_res),
        .redirect_ready_i  (redirect_ready_i),
        .issue_ready_o     (issue_ready_o),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_o        (redirect_o),
        .misaligned_o      (misaligned_o),
        .misaligned_addr_o (misaligned_addr_o),
        .link_valid_o      (link_valid_o),
        .link_o            (link_o)
    );

endmodule : branch_unit_top

/* tb/branch_vectors.svh */
// ~~~~~~~~~~~~~~~~~~~~
// branch unit vector table, one add_row per case
// valid, inst, pc, rs1, rs2, irq, irq addr, redirect, addr, misaligned, link, link value
// ~~~~~~~~~~~~~~~~~~~~

`ifndef BRANCH_VECTORS_SVH
`define BRANCH_VECTORS_SVH

localparam word_t NEG16 = 32'hFFFF_FFF0;  // -16 signed, huge unsigned

task automatic load_vectors();
    // forward branches, +0x40, fetch guessed not taken
    add_row(1, branch_inst(F_BEQ, 64), 'h1000, 5, 5, 0, 0, 1, 'h1040, 0, 0, 0);
    add_row(1, branch_inst(F_BEQ, 64), 'h1010, 5, 6, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BNE, 64), 'h1020, 5, 6, 0, 0, 1, 'h1060, 0, 0, 0);
    add_row(1, branch_inst(F_BNE, 64), 'h1030, 7, 7, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BLT, 64), 'h1040, NEG16, 1, 0, 0, 1, 'h1080, 0, 0, 0);
    add_row(1, branch_inst(F_BLT, 64), 'h1050, 1, NEG16, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BGE, 64), 'h1060, 1, NEG16, 0, 0, 1, 'h10A0, 0, 0, 0);
    add_row(1, branch_inst(F_BGE, 64), 'h1070, NEG16, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BLTU, 64), 'h1080, 1, NEG16, 0, 0, 1, 'h10C0, 0, 0, 0);
    add_row(1, branch_inst(F_BLTU, 64), 'h1090, NEG16, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BGEU, 64), 'h10A0, NEG16, 1, 0, 0, 1, 'h10E0, 0, 0, 0);
    add_row(1, branch_inst(F_BGEU, 64), 'h10B0, 1, NEG16, 0, 0, 0, 0, 0, 0, 0);

    // backward, -0x20, guessed taken
    add_row(1, branch_inst(F_BEQ, -32), 'h2000, 3, 3, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, branch_inst(F_BEQ, -32), 'h2010, 3, 4, 0, 0, 1, 'h2014, 0, 0, 0);  // rollback
    add_row(1, branch_inst(F_BLT, -32), 'h2020, 1, NEG16, 0, 0, 1, 'h2024, 0, 0, 0);
    add_row(1, branch_inst(F_BGEU, -32), 'h2030, NEG16, 1, 0, 0, 0, 0, 0, 0, 0);

    // jal and jalr, link is pc+4
    add_row(1, jal_inst('h100), 'h3000, 0, 0, 0, 0, 1, 'h3100, 0, 1, 'h3004);
    add_row(1, jal_inst(-8), 'h3010, 0, 0, 0, 0, 1, 'h3008, 0, 1, 'h3014);
    add_row(1, jalr_inst('h10), 'h3020, 'h4001, 0, 0, 0, 1, 'h4010, 0, 1, 'h3024);
    add_row(1, jalr_inst(-4), 'h3030, 'h5000, 0, 0, 0, 1, 'h4FFC, 0, 1, 'h3034);

    // fence refetch, interrupt override, idle interrupt
    add_row(1, FENCE, 'h6000, 0, 0, 0, 0, 1, 'h6004, 0, 0, 0);
    add_row(1, jal_inst('h100), 'h7000, 0, 0, 1, 'h80000100, 1, 'h80000100, 0, 0, 0);
    add_row(1, branch_inst(F_BEQ, 64), 'h7010, 1, 2, 1, 'h80000180, 1, 'h80000180, 0, 0, 0);
    add_row(0, NOP, 0, 0, 0, 1, 'h80000200, 1, 'h80000200, 0, 0, 0);
    add_row(1, NOP, 'h7020, 0, 0, 0, 0, 0, 0, 0, 0, 0);

    // unaligned targets trap, no redirect, no link
    add_row(1, jal_inst('h102), 'h3000, 0, 0, 0, 0, 0, 'h3102, 1, 0, 0);
    add_row(1, jalr_inst(6), 'h3040, 'h4000, 0, 0, 0, 0, 'h4006, 1, 0, 0);
    add_row(1, jalr_inst(3), 'h3050, 'h4000, 0, 0, 0, 0, 'h4002, 1, 0, 0);  // bit 0 dropped
endtask

`endif

/* tb/tb_branch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// branch unit testbench
// table stimulus, random fetch stalls, timeout
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_branch_unit import bru_cfg_pkg::*, bru_types_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 40;          // per row, stalls included
    localparam int SEED         = 94223;
    localparam logic [2:0] F_BEQ  = 3'b000;
    localparam logic [2:0] F_BNE  = 3'b001;
    localparam logic [2:0] F_BLT  = 3'b100;
    localparam logic [2:0] F_BGE  = 3'b101;
    localparam logic [2:0] F_BLTU = 3'b110;
    localparam logic [2:0] F_BGEU = 3'b111;
    localparam inst_t NOP   = 32'h0000_0013;   // addi x0, x0, 0
    localparam inst_t FENCE = 32'h0ff0_000f;

    typedef struct packed {
        logic  valid;      // low for an idle interrupt
        inst_t inst;
        addr_t pc;
        word_t rs1;
        word_t rs2;
        logic  irq;
        addr_t irq_addr;
        logic  exp_redir;
        addr_t exp_addr;   // redirect or faulting address
        logic  exp_mis;
        logic  exp_link;
        word_t exp_link_val;
    } vec_t;

    logic      clk;
    logic      reset_i;
    logic      issue_valid_i;
    logic      issue_ready_o;
    inst_t     issue_inst_i;
    addr_t     issue_pc_i;
    word_t     rs1_i;
    word_t     rs2_i;
    logic      int_assert_i;
    addr_t     int_addr_i;
    logic      redirect_valid_o;
    logic      redirect_ready_i;
    redirect_t redirect_o;
    logic      misaligned_o;
    addr_t     misaligned_addr_o;
    logic      link_valid_o;
    word_t     link_o;

    vec_t        vectors[$];
    int unsigned cycle_count;
    int unsigned cycle_limit;
    logic        redirect_taken;  // handshake on the last rising edge

    branch_unit_top dut_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .issue_valid_i     (issue_valid_i),
        .issue_ready_o     (issue_ready_o),
        .issue_inst_i      (issue_inst_i),
        .issue_pc_i        (issue_pc_i),
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .int_assert_i      (int_assert_i),
        .int_addr_i        (int_addr_i),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_ready_i  (redirect_ready_i),
        .redirect_o        (redirect_o),
        .misaligned_o      (misaligned_o),
        .misaligned_addr_o (misaligned_addr_o),
        .link_valid_o      (link_valid_o),
        .link_o            (link_o)
    );

    always #10 clk = ~clk;  // 20 ns period

    // rv32i encoders, rs1 = x1, rs2 = x2, rd = x1
    function automatic inst_t branch_inst(input logic [2:0] funct3, input int imm);
        logic [12:0] b;
        b = imm[12:0];
        return {b[12], b[10:5], 5'd2, 5'd1, funct3, b[4:1], b[11], 7'b1100011};
    endfunction

    function automatic inst_t jal_inst(input int imm);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic inst_t jalr_inst(input int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {i, 5'd1, 3'b000, 5'd1, 7'b1100111};
    endfunction

    function automatic void add_row(input int valid, input inst_t inst, input addr_t pc,
                                    input word_t rs1, input word_t rs2, input int irq,
                                    input addr_t irq_addr, input int redir, input addr_t addr,
                                    input int mis, input int link, input word_t link_val);
        vec_t v;
        v.valid        = (valid != 0);
        v.inst         = inst;
        v.pc           = pc;
        v.rs1          = rs1;
        v.rs2          = rs2;
        v.irq          = (irq != 0);
        v.irq_addr     = irq_addr;
        v.exp_redir    = (redir != 0);
        v.exp_addr     = addr;
        v.exp_mis      = (mis != 0);
        v.exp_link     = (link != 0);
        v.exp_link_val = link_val;
        vectors.push_back(v);
    endfunction

    `include "branch_vectors.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_row(input vec_t v);
        issue_valid_i = v.valid;
        issue_inst_i  = v.inst;
        issue_pc_i    = v.pc;
        rs1_i         = v.rs1;
        rs2_i         = v.rs2;
        int_assert_i  = v.irq;
        int_addr_i    = v.irq_addr;
    endtask

    task automatic idle_inputs();
        issue_valid_i = 1'b0;
        issue_inst_i  = NOP;
        issue_pc_i    = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        int_assert_i  = 1'b0;  // else an idle interrupt is taken
        int_addr_i    = '0;
    endtask

    // first cycle after accept
    task automatic check_response(input vec_t v);
        check_value("redirect_valid_o", redirect_valid_o, v.exp_redir);
        check_value("misaligned_o", misaligned_o, v.exp_mis);
        check_value("link_valid_o", link_valid_o, v.exp_link);
        check_value("issue_ready_o", issue_ready_o, !v.exp_redir);
        if (v.exp_redir) check_value("redirect_o.addr", redirect_o.addr, v.exp_addr);
        if (v.exp_mis) check_value("misaligned_addr_o", misaligned_addr_o, v.exp_addr);
        if (v.exp_link) check_value("link_o", link_o, v.exp_link_val);
    endtask

    // hold until fetch takes it, issue stays closed
    task automatic wait_redirect_taken(input addr_t addr);
        while (!redirect_taken) begin
            check_value("redirect_valid_o", redirect_valid_o, 1'b1);  // no drop while stalled
            check_value("redirect_o.addr", redirect_o.addr, addr);
            check_value("issue_ready_o", issue_ready_o, 1'b0);
            @(negedge clk);
        end
        check_value("redirect_valid_o", redirect_valid_o, 1'b0);  // gone after handshake
        check_value("issue_ready_o", issue_ready_o, 1'b1);
    endtask

    // fetch back-pressure, about half the cycles ready
    initial begin : fetch_stall_gen
        void'($urandom(SEED));
        redirect_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            redirect_ready_i = ($urandom() & 1) != 0;
        end
    end

    // valid and ready seen together on this edge
    always @(posedge clk) begin : handshake_mon
        redirect_taken = redirect_valid_o & redirect_ready_i;
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin : stimulus
        clk         = 1'b0;
        reset_i     = 1'b1;
        cycle_count = 0;
        idle_inputs();
        load_vectors();
        cycle_limit = RESET_CYCLES + vectors.size() * ROW_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        check_value("redirect_valid_o", redirect_valid_o, 1'b0);  // quiet out of reset
        check_value("misaligned_o", misaligned_o, 1'b0);
        check_value("link_valid_o", link_valid_o, 1'b0);
        check_value("issue_ready_o", issue_ready_o, 1'b1);

        foreach (vectors[i]) begin
            while (!issue_ready_o) @(negedge clk);
            drive_row(vectors[i]);
            @(negedge clk);                   // accepted on the edge just passed
            idle_inputs();
            check_response(vectors[i]);
            @(negedge clk);
            check_value("misaligned_o", misaligned_o, 1'b0);  // single cycle pulses
            check_value("link_valid_o", link_valid_o, 1'b0);
            if (vectors[i].exp_redir) wait_redirect_taken(vectors[i].exp_addr);
        end

        $display("sim passed");
        $finish;
    end

endmodule : tb_branch_unit

/* all.f */
+incdir+tb
hdl/bru_cfg_pkg.sv
hdl/bru_types_pkg.sv
hdl/branch_decoder.sv
hdl/exu_bru.sv
hdl/redirect_unit.sv
hdl/branch_unit_top.sv
tb/tb_branch_unit.sv

/* Bender.yml */
package:
  name: branch_unit

sources:
  # packages first, then rtl bottom up
  - files:
      - hdl/bru_cfg_pkg.sv
      - hdl/bru_types_pkg.sv
      - hdl/branch_decoder.sv
      - hdl/exu_bru.sv
      - hdl/redirect_unit.sv
      - hdl/branch_unit_top.sv

  # testbench, vector table lives in tb/
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_branch_unit.sv
